/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := stepper_ctrl_tb
FILELIST  := stepper_ctrl_top.f
BUILD_DIR := obj_dir
LOG       := sim.log
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* stepper_ctrl_top.f */
verilog/protocol_pkg.sv
verilog/motion_pkg.sv
verilog/spi_word_rx.sv
verilog/command_decoder.sv
verilog/move_queue.sv
verilog/dda_stepper.sv
verilog/hbridge_sequencer.sv
verilog/quad_encoder.sv
verilog/stepper_ctrl_top.sv
verification/stepper_ctrl_tb.sv

/* verification/stepper_ctrl_tb.sv */
`timescale 1ns/1ps

module stepper_ctrl_tb
  import protocol_pkg::*;
  import motion_pkg::*;
();

  // About 20 transfers of roughly 540 cycles plus three short moves, with wide margin
  localparam int          TIMEOUT_CYCLES = 200000;
  localparam int          SCK_HALF       = 4;
  localparam logic [31:0] SEED           = 32'ha077e6c3;
  localparam clk_div_t    TEST_DIV       = 8'd3;
  localparam host_word_t  IDLE_WORD      = 64'h0;

  // Move parameters, second move ramps down
  localparam position_t DUR1    = 64'd19;
  localparam position_t INC1    = 64'h2000_0000_0000_0000;
  localparam position_t INCINC1 = 64'h0100_0000_0000_0000;
  localparam position_t DUR2    = 64'd24;
  localparam position_t INC2    = 64'h1800_0000_0000_0000;
  localparam position_t INCINC2 = 64'hffc0_0000_0000_0000;

  logic CLK;
  logic arst_n;
  logic sck;
  logic cs_n;
  logic copi;
  logic enc_a;
  logic enc_b;
  logic cipo;
  logic led;
  logic phase_a1;
  logic phase_a2;
  logic phase_b1;
  logic phase_b2;
  logic enc_fault;
  logic [3:0] phases;

  int         check_errors = 0;
  int         monitor_errors = 0;
  int         assert_errors = 0;
  int         cycle_count = 0;
  int         steps_seen = 0;
  int         exp_delta = 1;
  int         step_delta;
  logic [3:0] prev_phases = 4'b0000;
  logic       motor_on = 1'b0;
  logic       fault_driven = 1'b0;
  position_t  model_acc = '0;
  string      test_name = "none";

  stepper_ctrl_top #(.MOVE_DEPTH(4)) uut (
    .CLK(CLK), .arst_n(arst_n), .sck(sck), .cs_n(cs_n), .copi(copi),
    .enc_a(enc_a), .enc_b(enc_b), .cipo(cipo), .led(led),
    .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1),
    .phase_b2(phase_b2), .enc_fault(enc_fault)
  );

  assign phases = {phase_a1, phase_a2, phase_b1, phase_b2};

  always #20 CLK = ~CLK;

  always @(posedge CLK) cycle_count <= cycle_count + 1;

  // Standard two-coil half-step sequence, {a1, a2, b1, b2}
  function automatic int pattern_index(input logic [3:0] p);
    case (p)
      4'b1000: return 0;
      4'b1010: return 1;
      4'b0010: return 2;
      4'b0110: return 3;
      4'b0100: return 4;
      4'b0101: return 5;
      4'b0001: return 6;
      4'b1001: return 7;
      default: return -1;
    endcase
  endfunction

  function automatic host_word_t cmd_word(input cmd_t cmd, input logic [55:0] arg);
    return {cmd, arg};
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      check_errors++;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // One mode 0 frame, reply sampled just before each rising SCK
  task automatic transfer(input host_word_t tx, output host_word_t rx);
    logic led_before;
    led_before = led;
    @(posedge CLK);
    cs_n <= 1'b0;
    repeat (SCK_HALF) @(posedge CLK);
    for (int i = 63; i >= 0; i--) begin
      copi <= tx[i];
      repeat (SCK_HALF - 1) @(posedge CLK);
      @(negedge CLK);
      rx[i] = cipo;
      @(posedge CLK);
      sck <= 1'b1;
      repeat (SCK_HALF) @(posedge CLK);
      sck <= 1'b0;
    end
    repeat (SCK_HALF) @(posedge CLK);
    cs_n <= 1'b1;
    repeat (2 * SCK_HALF) @(posedge CLK);
    @(negedge CLK);
    // Every received word flips the LED
    check_value({test_name, " led toggle"}, 64'(!led_before), 64'(led));
  endtask

  task automatic send_move(input logic dir, input position_t dur, input position_t inc,
                           input position_t inc_inc);
    host_word_t reply;
    transfer(cmd_word(CMD_COORDINATED_STEP, {55'd0, dir}), reply);
    transfer(host_word_t'(dur), reply);
    transfer(host_word_t'(inc), reply);
    transfer(host_word_t'(inc_inc), reply);
  endtask

  // Segment length is fixed by divisor and duration
  task automatic wait_segment(input position_t dur);
    repeat ((int'(dur) + 1) * (int'(TEST_DIV) + 1) + 16) @(posedge CLK);
  endtask

  // Reference DDA, accumulator carried across segments
  task automatic run_model(input position_t dur, input position_t inc,
                           input position_t inc_inc, output int steps);
    position_t s;
    position_t cur_inc;
    steps = 0;
    cur_inc = inc;
    for (position_t t = 0; t <= dur; t++) begin
      s = model_acc + cur_inc;
      if (s > 0) begin
        steps++;
        s = s - STEP_THRESHOLD;
      end
      model_acc = s;
      cur_inc = cur_inc + inc_inc;
    end
  endtask

  // Gray-code edge, held long enough for the synchronizer
  task automatic encoder_edge(input logic forward);
    @(posedge CLK);
    if (forward == (enc_a == enc_b)) begin
      enc_a <= !enc_a;
    end else begin
      enc_b <= !enc_b;
    end
    repeat (3) @(posedge CLK);
  endtask

  task automatic end_of_run(input logic timed_out);
    int total;
    total = check_errors + monitor_errors + assert_errors;
    $display("Errors: checks %0d, step monitor %0d, assertions %0d, total %0d",
             check_errors, monitor_errors, assert_errors, total);
    if (timed_out || total != 0) begin
      $display("ERRORS FOUND");
    end else begin
      $display("NO ERRORS");
    end
    $finish;
  endtask

  // Each pattern change is one step, index moves by the expected stride
  always @(negedge CLK) begin
    if (arst_n && prev_phases != 4'b0 && phases != 4'b0 && phases != prev_phases) begin
      steps_seen++;
      step_delta = (pattern_index(phases) - pattern_index(prev_phases)) & 7;
      assert (step_delta == exp_delta) else begin
        monitor_errors++;
        $display("MISMATCH %s stride expected %0d actual %0d", test_name, exp_delta,
                 step_delta);
      end
    end
    prev_phases = phases;
  end

  a_off_when_disabled : assert property (@(posedge CLK) disable iff (!arst_n)
    !motor_on |-> phases == 4'b0000)
    else begin
      assert_errors++;
      $display("Bridge outputs driven while the motor is disabled");
    end

  a_legal_pattern : assert property (@(posedge CLK) disable iff (!arst_n)
    motor_on |-> (phases == 4'b0000 || pattern_index(phases) >= 0))
    else begin
      assert_errors++;
      $display("Bridge outputs show a pattern outside the half-step table");
    end

  a_no_early_fault : assert property (@(posedge CLK) disable iff (!arst_n)
    !fault_driven |-> !enc_fault)
    else begin
      assert_errors++;
      $display("Encoder fault raised by legal quadrature edges");
    end

  a_fault_sticky : assert property (@(posedge CLK) disable iff (!arst_n)
    enc_fault |=> enc_fault)
    else begin
      assert_errors++;
      $display("Encoder fault cleared without a reset");
    end

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end_of_run(1'b1);
  end

  initial begin
    host_word_t reply;
    int         model_steps;
    int         base;
    int         fwd;
    int         back;
    CLK    = 1'b0;
    arst_n = 1'b0;
    sck    = 1'b0;
    cs_n   = 1'b1;
    copi   = 1'b0;
    enc_a  = 1'b0;
    enc_b  = 1'b0;
    void'($urandom(SEED));
    repeat (5) @(posedge CLK);
    arst_n <= 1'b1;
    @(negedge CLK);

    test_name = "reset";
    check_value("reset phases", 64'h0, 64'(phases));
    check_value("reset led", 64'h0, 64'(led));
    check_value("reset enc_fault", 64'h0, 64'(enc_fault));
    transfer(IDLE_WORD, reply);
    check_value("first reply", 64'h0, reply);

    // Version shows up one transfer later
    test_name = "api version";
    transfer(cmd_word(CMD_API_VERSION, 56'd0), reply);
    transfer(IDLE_WORD, reply);
    check_value("api version",
                {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH}, reply);

    test_name = "disabled move";
    transfer(cmd_word(CMD_CLK_DIVISOR, 56'(TEST_DIV)), reply);
    send_move(1'b1, DUR1, INC1, INCINC1);
    wait_segment(DUR1);
    run_model(DUR1, INC1, INCINC1, model_steps);
    motor_on = 1'b1;
    transfer(cmd_word(CMD_MOTOR_ENABLE, 56'd1), reply);
    check_value("enable pattern valid", 64'h1, 64'(pattern_index(phases) >= 0));

    // Half step forward
    test_name = "half-step move";
    exp_delta = 1;
    base = steps_seen;
    send_move(1'b1, DUR1, INC1, INCINC1);
    wait_segment(DUR1);
    run_model(DUR1, INC1, INCINC1, model_steps);
    check_value("half-step count", 64'(model_steps), 64'(steps_seen - base));

    // Full step backward, index retreats by two
    test_name = "full-step move";
    transfer(cmd_word(CMD_MICROSTEPS, 56'd1), reply);
    exp_delta = 6;
    base = steps_seen;
    send_move(1'b0, DUR2, INC2, INCINC2);
    wait_segment(DUR2);
    run_model(DUR2, INC2, INCINC2, model_steps);
    check_value("full-step count", 64'(model_steps), 64'(steps_seen - base));

    test_name = "encoder count";
    fwd  = 10 + int'($urandom % 30);
    back = int'($urandom % 20);
    repeat (fwd) encoder_edge(1'b1);
    repeat (back) encoder_edge(1'b0);
    repeat (4) @(posedge CLK);
    // First transfer latches the count, second returns it
    transfer(IDLE_WORD, reply);
    transfer(IDLE_WORD, reply);
    check_value("encoder count", host_word_t'(position_t'(fwd - back)), reply);

    test_name = "encoder fault";
    check_value("fault before", 64'h0, 64'(enc_fault));
    @(posedge CLK);
    fault_driven = 1'b1;
    enc_a <= !enc_a;
    enc_b <= !enc_b;
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    check_value("fault set", 64'h1, 64'(enc_fault));
    repeat (4) encoder_edge(1'b1);
    @(negedge CLK);
    check_value("fault held", 64'h1, 64'(enc_fault));

    end_of_run(1'b0);
  end

endmodule

/* verilog/command_decoder.sv */
`timescale 1ns/1ps

module command_decoder
  import protocol_pkg::*;
  import motion_pkg::*;
(
  input  logic       CLK,
  input  logic       arst_n,
  input  logic       word_valid,
  input  host_word_t rx_word,
  input  position_t  enc_count,
  output host_word_t tx_word,
  output logic       push,
  output move_seg_t  seg,
  output logic       enable,
  output clk_div_t   clk_div,
  output microstep_t microsteps,
  output logic       led
);

  // Reset defaults for the setting registers
  localparam clk_div_t   CLK_DIV_RESET   = 8'd40;
  localparam microstep_t MICROSTEP_RESET = 3'd2;

  typedef enum logic [2:0] {
    HEADER,
    MOVE_DUR,
    MOVE_INC,
    MOVE_INCINC,
    SKIP
  } dec_state_t;

  dec_state_t state;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state      <= HEADER;
      tx_word    <= '0;
      push       <= 1'b0;
      enable     <= 1'b0;
      clk_div    <= CLK_DIV_RESET;
      microsteps <= MICROSTEP_RESET;
      led        <= 1'b0;
    end else begin
      push <= 1'b0;
      if (word_valid) begin
        led <= !led;
        // Live encoder count unless a command overrides it
        tx_word <= host_word_t'(enc_count);
        case (state)
          HEADER: begin
            case (cmd_t'(rx_word[63:56]))
              CMD_COORDINATED_STEP: state <= MOVE_DUR;
              CMD_MOTOR_ENABLE:     enable <= rx_word[0];
              CMD_CLK_DIVISOR:      clk_div <= rx_word[7:0];
              CMD_MICROSTEPS:       microsteps <= rx_word[2:0];
              CMD_API_VERSION: begin
                tx_word <= {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
                // Host sends a filler word to collect the version
                state   <= SKIP;
              end
              default: state <= HEADER;
            endcase
          end
          MOVE_DUR: state <= MOVE_INC;
          MOVE_INC: state <= MOVE_INCINC;
          MOVE_INCINC: begin
            // Segment is complete with the third data word
            push  <= 1'b1;
            state <= HEADER;
          end
          default: state <= HEADER;
        endcase
      end
    end
  end

  // Segment under assembly with dir taken from the header word
  always_ff @(posedge CLK) begin
    if (word_valid) begin
      case (state)
        HEADER:      seg.dir       <= rx_word[0];
        MOVE_DUR:    seg.duration  <= position_t'(rx_word);
        MOVE_INC:    seg.increment <= position_t'(rx_word);
        MOVE_INCINC: seg.inc_inc   <= position_t'(rx_word);
        default:     ;
      endcase
    end
  end

  // Queue sees exactly one push per move command
  a_push_pulse : assert property (@(posedge CLK) disable iff (!arst_n)
    push |=> !push)
    else $error("command_decoder: push wider than one cycle");

endmodule

/* verilog/dda_stepper.sv */
`timescale 1ns/1ps

module dda_stepper
  import motion_pkg::*;
(
  input  logic      CLK,
  input  logic      arst_n,
  input  move_seg_t head,
  input  logic      not_empty,
  input  clk_div_t  clk_div,
  output logic      pop,
  output logic      step,
  output logic      dir
);

  typedef enum logic {
    IDLE,
    RUN
  } dda_state_t;

  dda_state_t state;
  clk_div_t   div_cnt;
  position_t  ticks_left;
  position_t  increment;
  position_t  accum;
  position_t  acc_sum;
  logic       tick;
  logic       load;

  assign load    = (state == IDLE) && not_empty;
  assign tick    = (state == RUN) && (div_cnt == '0);
  assign acc_sum = accum + increment;
  // Segment done on its last tick, head moves on at the same edge
  assign pop     = tick && (ticks_left == '0);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state   <= IDLE;
      div_cnt <= '0;
      accum   <= '0;
      step    <= 1'b0;
      dir     <= 1'b0;
    end else begin
      step <= 1'b0;
      if (load) begin
        state   <= RUN;
        div_cnt <= clk_div;
        dir     <= head.dir;
      end else if (tick) begin
        div_cnt <= clk_div;
        // Accumulator keeps its remainder across segments
        if (acc_sum > 0) begin
          step  <= 1'b1;
          accum <= acc_sum - STEP_THRESHOLD;
        end else begin
          accum <= acc_sum;
        end
        if (pop) begin
          state <= IDLE;
        end
      end else if (state == RUN) begin
        div_cnt <= div_cnt - 8'd1;
      end
    end
  end

  // Running increment ramps by inc_inc after each tick
  always_ff @(posedge CLK) begin
    if (load) begin
      ticks_left <= head.duration;
      increment  <= head.increment;
    end else if (tick) begin
      ticks_left <= ticks_left - 1;
      increment  <= increment + head.inc_inc;
    end
  end

endmodule

/* verilog/hbridge_sequencer.sv */
`timescale 1ns/1ps

module hbridge_sequencer
  import motion_pkg::*;
(
  input  logic       CLK,
  input  logic       arst_n,
  input  logic       step,
  input  logic       dir,
  input  logic       enable,
  input  microstep_t microsteps,
  output logic       phase_a1,
  output logic       phase_a2,
  output logic       phase_b1,
  output logic       phase_b2
);

  logic [2:0] phase_idx;
  logic [2:0] stride;
  logic [2:0] idx_next;
  logic [3:0] drive;

  // Half-step table, {a1, a2, b1, b2}
  function automatic logic [3:0] half_step_pattern(input logic [2:0] idx);
    case (idx)
      3'd0:    return 4'b1000;
      3'd1:    return 4'b1010;
      3'd2:    return 4'b0010;
      3'd3:    return 4'b0110;
      3'd4:    return 4'b0100;
      3'd5:    return 4'b0101;
      3'd6:    return 4'b0001;
      default: return 4'b1001;
    endcase
  endfunction

  // Full step skips every other table entry
  assign stride   = (microsteps == 3'd1) ? 3'd2 : 3'd1;
  assign idx_next = !step ? phase_idx : dir ? phase_idx + stride : phase_idx - stride;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      phase_idx <= '0;
      drive     <= '0;
    end else begin
      phase_idx <= idx_next;
      drive     <= half_step_pattern(idx_next);
    end
  end

  // Disabled bridge floats both coils
  assign {phase_a1, phase_a2, phase_b1, phase_b2} = drive & {4{enable}};

endmodule

/* verilog/motion_pkg.sv */
package motion_pkg;

  // Encoder count, DDA accumulator and increments
  typedef logic signed [63:0] position_t;
  // Idle CLK cycles between DDA ticks
  typedef logic [7:0] clk_div_t;
  // Step mode, 1 is full step, anything else half step
  typedef logic [2:0] microstep_t;

  // One queued move segment
  typedef struct packed {
    logic      dir;
    position_t duration;
    position_t increment;
    position_t inc_inc;
  } move_seg_t;

  // Subtracted from the accumulator on every step
  localparam position_t STEP_THRESHOLD = 64'h7fffffffffffff9b;

endpackage

/* verilog/move_queue.sv */
`timescale 1ns/1ps

module move_queue
  import motion_pkg::*;
#(
  parameter int MOVE_DEPTH = 4
) (
  input  logic      CLK,
  input  logic      arst_n,
  input  logic      push,
  input  logic      pop,
  input  move_seg_t seg_in,
  output move_seg_t head,
  output logic      not_empty
);

  localparam int PTR_W = (MOVE_DEPTH > 1) ? $clog2(MOVE_DEPTH) : 1;
  localparam int CNT_W = $clog2(MOVE_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(MOVE_DEPTH - 1);

  move_seg_t        mem [MOVE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= seg_in;
    end
  end

  // Pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Host paces moves, step generator only pops what it loaded
  a_no_overflow : assert property (@(posedge CLK) disable iff (!arst_n)
    push |-> count != CNT_W'(MOVE_DEPTH))
    else $error("move_queue: push while full");
  a_no_underflow : assert property (@(posedge CLK) disable iff (!arst_n)
    pop |-> not_empty)
    else $error("move_queue: pop while empty");

endmodule

/* verilog/protocol_pkg.sv */
package protocol_pkg;

  // One SPI transfer, either direction
  typedef logic [63:0] host_word_t;

  // Header byte, bits 63:56 of the first word of a command
  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'h01,
    CMD_MOTOR_ENABLE     = 8'h0a,
    CMD_CLK_DIVISOR      = 8'h0b,
    CMD_MICROSTEPS       = 8'h0c,
    CMD_API_VERSION      = 8'hfe
  } cmd_t;

  // API version returned after CMD_API_VERSION
  localparam logic [7:0] VERSION_MAJOR = 8'd0;
  localparam logic [7:0] VERSION_MINOR = 8'd1;
  localparam logic [7:0] VERSION_PATCH = 8'd0;

endpackage

/* verilog/quad_encoder.sv */
`timescale 1ns/1ps

module quad_encoder
  import motion_pkg::*;
(
  input  logic      CLK,
  input  logic      arst_n,
  input  logic      enc_a,
  input  logic      enc_b,
  output position_t count,
  output logic      fault
);

  // Two sync stages plus the previous sample
  logic [2:0] a_sync;
  logic [2:0] b_sync;
  logic       a_chg;
  logic       b_chg;
  logic       up;

  assign a_chg = a_sync[1] ^ a_sync[2];
  assign b_chg = b_sync[1] ^ b_sync[2];
  // A leading B gives new A differing from old B
  assign up    = a_sync[1] ^ b_sync[2];

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      a_sync <= '0;
      b_sync <= '0;
      count  <= '0;
      fault  <= 1'b0;
    end else begin
      a_sync <= {a_sync[1:0], enc_a};
      b_sync <= {b_sync[1:0], enc_b};
      if (a_chg && b_chg) begin
        // Skipped Gray state, direction unknown, sticky until reset
        fault <= 1'b1;
      end else if (a_chg || b_chg) begin
        count <= up ? count + 1 : count - 1;
      end
    end
  end

endmodule

/* verilog/spi_word_rx.sv */
`timescale 1ns/1ps

module spi_word_rx
  import protocol_pkg::*;
(
  input  logic       CLK,
  input  logic       arst_n,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       copi,
  input  host_word_t tx_word,
  output logic       cipo,
  output logic       word_valid,
  output host_word_t rx_word
);

  // Bit 0 is the first flop, bit 2 the delayed copy for edge detect
  logic [2:0] sck_sync;
  logic [2:0] cs_sync;
  logic [1:0] copi_sync;
  logic       cs_active;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_fall;
  logic       copi_bit;
  logic [6:0] bit_cnt;
  host_word_t shreg;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      sck_sync  <= '0;
      cs_sync   <= '1;
      copi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[1:0], cs_n};
      copi_sync <= {copi_sync[0], copi};
    end
  end

  // SCK edges only count inside a frame
  assign cs_active = !cs_sync[1];
  assign sck_rise  = cs_active && sck_sync[1] && !sck_sync[2];
  assign sck_fall  = cs_active && !sck_sync[1] && sck_sync[2];
  assign cs_fall   = !cs_sync[1] && cs_sync[2];

  // MSB of the shared shift register drives the host
  assign cipo = shreg[63];

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      shreg      <= '0;
      copi_bit   <= 1'b0;
      bit_cnt    <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (cs_fall) begin
        // Reply word goes out in this frame
        shreg   <= tx_word;
        bit_cnt <= '0;
      end else if (sck_rise) begin
        // Mode 0, sample on the rising edge
        copi_bit <= copi_sync[1];
        bit_cnt  <= bit_cnt + 7'd1;
        if (bit_cnt == 7'd63) begin
          word_valid <= 1'b1;
        end
      end else if (sck_fall) begin
        // Shift out next bit, shift in the held sample
        shreg <= {shreg[62:0], copi_bit};
      end
    end
  end

  // Last bit is still in flight, append it directly
  always_ff @(posedge CLK) begin
    if (sck_rise && bit_cnt == 7'd63) begin
      rx_word <= {shreg[62:0], copi_sync[1]};
    end
  end

  // Host must not clock more than one word per frame
  a_frame_len : assert property (@(posedge CLK) disable iff (!arst_n)
    cs_active |-> bit_cnt <= 7'd64)
    else $error("spi_word_rx: more than 64 SCK edges in one frame");

endmodule

/* verilog/stepper_ctrl_top.sv */
`timescale 1ns/1ps

module stepper_ctrl_top
  import protocol_pkg::*;
  import motion_pkg::*;
#(
  parameter int MOVE_DEPTH = 4
) (
  input  logic CLK,
  input  logic arst_n,
  input  logic sck,
  input  logic cs_n,
  input  logic copi,
  input  logic enc_a,
  input  logic enc_b,
  output logic cipo,
  output logic led,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic enc_fault
);

  host_word_t rx_word;
  host_word_t tx_word;
  logic       word_valid;
  position_t  enc_count;
  move_seg_t  seg;
  move_seg_t  head;
  logic       push;
  logic       pop;
  logic       not_empty;
  logic       enable;
  clk_div_t   clk_div;
  microstep_t microsteps;
  logic       step;
  logic       dir;

  // SPI front end
  spi_word_rx u_spi (
    .CLK(CLK), .arst_n(arst_n), .sck(sck), .cs_n(cs_n), .copi(copi),
    .tx_word(tx_word), .cipo(cipo), .word_valid(word_valid), .rx_word(rx_word)
  );

  command_decoder u_dec (
    .CLK(CLK), .arst_n(arst_n), .word_valid(word_valid), .rx_word(rx_word),
    .enc_count(enc_count), .tx_word(tx_word), .push(push), .seg(seg),
    .enable(enable), .clk_div(clk_div), .microsteps(microsteps), .led(led)
  );

  // Segments wait here until the step generator is free
  move_queue #(.MOVE_DEPTH(MOVE_DEPTH)) u_queue (
    .CLK(CLK), .arst_n(arst_n), .push(push), .pop(pop), .seg_in(seg),
    .head(head), .not_empty(not_empty)
  );

  dda_stepper u_dda (
    .CLK(CLK), .arst_n(arst_n), .head(head), .not_empty(not_empty),
    .clk_div(clk_div), .pop(pop), .step(step), .dir(dir)
  );

  hbridge_sequencer u_bridge (
    .CLK(CLK), .arst_n(arst_n), .step(step), .dir(dir), .enable(enable),
    .microsteps(microsteps), .phase_a1(phase_a1), .phase_a2(phase_a2),
    .phase_b1(phase_b1), .phase_b2(phase_b2)
  );

  quad_encoder u_enc (
    .CLK(CLK), .arst_n(arst_n), .enc_a(enc_a), .enc_b(enc_b),
    .count(enc_count), .fault(enc_fault)
  );

endmodule
